/* rtl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  ////////////////////
  // cache geometry
  ////////////////////

  // read ports competing for the arrays
  localparam int unsigned NUM_PORTS   = 3;
  // associativity
  localparam int unsigned NUM_WAYS    = 4;
  // one bank per word of a line
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned WORD_WIDTH  = 32;
  localparam int unsigned WORD_BYTES  = 4;
  localparam int unsigned NUM_SETS    = 16;
  localparam int unsigned TAG_WIDTH   = 8;
  // data word plus one parity bit per byte
  localparam int unsigned PWORD_WIDTH = WORD_WIDTH + WORD_BYTES;

  ////////////////////
  // vector types
  ////////////////////

  typedef logic [WORD_WIDTH-1:0]  word_t;
  typedef logic [WORD_BYTES-1:0]  be_t;
  typedef logic [PWORD_WIDTH-1:0] pword_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [$clog2(NUM_SETS)-1:0] idx_t;

  // upper bits pick the bank, lower bits the byte
  typedef logic [$clog2(NUM_BANKS*WORD_BYTES)-1:0] off_t;

  typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;
  typedef logic [NUM_BANKS-1:0]         bank_oh_t;
  typedef logic [NUM_WAYS-1:0]          way_oh_t;
  typedef logic [NUM_PORTS-1:0]         port_oh_t;
  typedef logic [$clog2(NUM_PORTS)-1:0] port_sel_t;

  // full line as written by a refill
  typedef logic [NUM_BANKS*WORD_WIDTH-1:0] line_t;
  typedef logic [NUM_BANKS*WORD_BYTES-1:0] line_be_t;

endpackage

`default_nettype wire

/* rtl/dcache_data_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data_bank (
  input  logic                                       clk_i,
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  dcache_pkg::idx_t                           idx_i,
  input  dcache_pkg::way_oh_t                        way_we_i,
  input  dcache_pkg::be_t   [dcache_pkg::NUM_WAYS-1:0] be_i,
  input  dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] wdata_i,
  output dcache_pkg::word_t [dcache_pkg::NUM_WAYS-1:0] rdata_o,
  output dcache_pkg::be_t   [dcache_pkg::NUM_WAYS-1:0] err_o
);

  import dcache_pkg::*;

  // byte b sits in bits [9b+7:9b], its parity in bit 9b+8
  pword_t [NUM_WAYS-1:0] pwdata;
  pword_t [NUM_WAYS-1:0] prdata_q;

  // one entry per set and way
  pword_t mem_q [NUM_SETS][NUM_WAYS];

  ////////////////////
  // parity codec
  ////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    for (genvar b = 0; b < WORD_BYTES; b++) begin : gen_byte
      // even parity over each byte
      assign pwdata[w][b*9 +: 8] = wdata_i[w][b*8 +: 8];
      assign pwdata[w][b*9 + 8]  = ^wdata_i[w][b*8 +: 8];

      assign rdata_o[w][b*8 +: 8] = prdata_q[w][b*9 +: 8];
      // odd count over data and parity means a flipped bit
      assign err_o[w][b] = ^prdata_q[w][b*9 +: 9];
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      for (int unsigned w = 0; w < NUM_WAYS; w++) begin
        for (int unsigned b = 0; b < WORD_BYTES; b++) begin
          // only enabled bytes of enabled ways change
          if (way_we_i[w] && be_i[w][b]) begin
            mem_q[idx_i][w][b*9 +: 9] <= pwdata[w][b*9 +: 9];
          end
        end
      end
    end
  end

  // readout lands one cycle after the request
  always_ff @(posedge clk_i) begin : p_read
    if (req_i && !we_i) begin
      for (int unsigned w = 0; w < NUM_WAYS; w++) begin
        prdata_q[w] <= mem_q[idx_i][w];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_tag_array.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
  input  logic                                      clk_i,
  input  dcache_pkg::way_oh_t                       req_i,
  input  logic                                      we_i,
  input  dcache_pkg::idx_t                          idx_i,
  input  dcache_pkg::tag_t                          tag_i,
  input  dcache_pkg::way_oh_t                       vld_i,
  output dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] tag_o,
  output dcache_pkg::way_oh_t                       vld_o
);

  import dcache_pkg::*;

  // entry layout: {valid copy 1, valid copy 0, tag parity, tag}
  typedef logic [TAG_WIDTH+2:0] tag_entry_t;

  tag_entry_t [NUM_WAYS-1:0] wentry;
  tag_entry_t [NUM_WAYS-1:0] rentry_q;

  tag_entry_t mem_q [NUM_SETS][NUM_WAYS];

  // valid bit stored twice, tag carries even parity
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    assign wentry[w] = {vld_i[w], vld_i[w], ^tag_i, tag_i};

    assign tag_o[w] = rentry_q[w][TAG_WIDTH-1:0];

    // both copies set and tag parity clean, anything else reads invalid
    assign vld_o[w] = rentry_q[w][TAG_WIDTH+2] & rentry_q[w][TAG_WIDTH+1]
                    & ~(^rentry_q[w][TAG_WIDTH:0]);
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk_i) begin : p_write
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (req_i[w] && we_i) begin
        mem_q[idx_i][w] <= wentry[w];
      end
    end
  end

  // same read latency as the data banks
  always_ff @(posedge clk_i) begin : p_read
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (req_i[w] && !we_i) begin
        rentry_q[w] <= mem_q[idx_i][w];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_port_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_port_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  dcache_pkg::port_oh_t                           rd_req_i,
  input  dcache_pkg::port_oh_t                           rd_prio_i,
  input  dcache_pkg::idx_t   [dcache_pkg::NUM_PORTS-1:0] rd_idx_i,
  input  dcache_pkg::off_t   [dcache_pkg::NUM_PORTS-1:0] rd_off_i,
  input  logic                                           wr_cl_vld_i,
  input  dcache_pkg::way_oh_t                            wr_cl_we_i,
  input  dcache_pkg::idx_t                               wr_cl_idx_i,
  input  dcache_pkg::way_oh_t                            wr_req_i,
  input  dcache_pkg::off_t                               wr_off_i,
  input  dcache_pkg::idx_t                               wr_idx_i,
  output dcache_pkg::port_oh_t                           rd_ack_o,
  output dcache_pkg::port_sel_t                          rd_sel_o,
  output dcache_pkg::off_t                               rd_off_o,
  output logic                                           lookup_o,
  output dcache_pkg::bank_oh_t                           bank_req_o,
  output dcache_pkg::bank_oh_t                           bank_we_o,
  output dcache_pkg::idx_t   [dcache_pkg::NUM_BANKS-1:0] bank_idx_o,
  output dcache_pkg::way_oh_t                            tag_req_o,
  output logic                                           tag_we_o,
  output dcache_pkg::idx_t                               tag_idx_o,
  output logic                                           wr_ack_o
);

  import dcache_pkg::*;

  port_oh_t  rd_req_prio;
  port_oh_t  rd_req_masked;
  port_sel_t rr_q;
  port_sel_t rr_d;
  port_sel_t sel;
  logic      found;
  logic      rd_gnt;
  bank_sel_t rd_bank;
  bank_sel_t wr_bank;

  ////////////////////
  // read arbitration
  ////////////////////

  // any high prio request masks all low prio ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first competitor at or after the pointer wins
  always_comb begin : p_rr_pick
    int unsigned cand;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      cand = (int'(rr_q) + i) % NUM_PORTS;
      if (!found && rd_req_masked[cand]) begin
        found = 1'b1;
        sel   = port_sel_t'(cand);
      end
    end
  end

  // refill owns the arrays, no read grant meanwhile
  assign rd_gnt = found & ~wr_cl_vld_i;

  always_comb begin : p_ack
    rd_ack_o = '0;
    if (rd_gnt) begin
      rd_ack_o[sel] = 1'b1;
    end
  end

  // pointer moves past the winner, only on a grant
  assign rr_d = rd_gnt ? port_sel_t'((int'(sel) + 1) % NUM_PORTS) : rr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  // lookup info for the hit selector
  assign rd_sel_o = sel;
  assign rd_off_o = rd_off_i[sel];
  assign lookup_o = rd_gnt;

  // tags: refill writes the chosen ways, a read looks at all of them
  assign tag_we_o  = wr_cl_vld_i;
  assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : (rd_gnt ? '1 : '0);
  assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[sel];

  ////////////////////
  // bank steering
  ////////////////////

  assign rd_bank = bank_sel_t'(rd_off_i[sel] >> $clog2(WORD_BYTES));
  assign wr_bank = bank_sel_t'(wr_off_i >> $clog2(WORD_BYTES));

  always_comb begin : p_bank_req
    bank_req_o = '0;
    bank_we_o  = '0;
    wr_ack_o   = 1'b0;
    for (int unsigned k = 0; k < NUM_BANKS; k++) begin
      bank_idx_o[k] = wr_cl_vld_i ? wr_cl_idx_i : wr_idx_i;
    end

    if (wr_cl_vld_i) begin
      // whole line goes into every bank
      bank_req_o = '1;
      bank_we_o  = '1;
    end else begin
      if (rd_gnt) begin
        bank_req_o[rd_bank] = 1'b1;
        bank_idx_o[rd_bank] = rd_idx_i[sel];
      end
      // word write only when it stays off the read bank
      if ((|wr_req_i) && !(rd_gnt && (rd_bank == wr_bank))) begin
        wr_ack_o            = 1'b1;
        bank_req_o[wr_bank] = 1'b1;
        bank_we_o[wr_bank]  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_hit_select.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_hit_select (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        lookup_i,
  input  dcache_pkg::port_sel_t                       rd_sel_i,
  input  dcache_pkg::off_t                            rd_off_i,
  input  dcache_pkg::tag_t [dcache_pkg::NUM_PORTS-1:0]  rd_tag_i,
  input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0]   tag_i,
  input  dcache_pkg::way_oh_t                         vld_i,
  input  dcache_pkg::word_t
         [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_rdata_i,
  input  dcache_pkg::be_t
         [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_err_i,
  output dcache_pkg::way_oh_t                         rd_vld_bits_o,
  output dcache_pkg::way_oh_t                         rd_hit_oh_o,
  output dcache_pkg::word_t                           rd_data_o,
  output logic                                        rd_err_o
);

  import dcache_pkg::*;

  // lookup state of the grant one cycle back
  logic      lookup_q;
  port_sel_t sel_q;
  off_t      off_q;
  tag_t      rd_tag;
  bank_sel_t bank_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      lookup_q <= 1'b0;
      sel_q    <= '0;
      off_q    <= '0;
    end else begin
      lookup_q <= lookup_i;
      sel_q    <= rd_sel_i;
      off_q    <= rd_off_i;
    end
  end

  // requester supplies its tag in this cycle
  assign rd_tag = rd_tag_i[sel_q];
  assign bank_q = bank_sel_t'(off_q >> $clog2(WORD_BYTES));

  ////////////////////
  // tag compare
  ////////////////////

  assign rd_vld_bits_o = vld_i;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign rd_hit_oh_o[w] = lookup_q & vld_i[w] & (tag_i[w] == rd_tag);
  end

  // and-or mux over the hit ways of the addressed bank
  always_comb begin : p_word_sel
    rd_data_o = '0;
    rd_err_o  = 1'b0;
    for (int unsigned w = 0; w < NUM_WAYS; w++) begin
      if (rd_hit_oh_o[w]) begin
        rd_data_o = rd_data_o | bank_rdata_i[bank_q][w];
        // parity error only matters on the word we return
        rd_err_o  = rd_err_o | (|bank_err_i[bank_q][w]);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_mem (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // read ports
  input  dcache_pkg::port_oh_t                           rd_req_i,
  input  dcache_pkg::port_oh_t                           rd_prio_i,
  input  dcache_pkg::idx_t   [dcache_pkg::NUM_PORTS-1:0] rd_idx_i,
  input  dcache_pkg::off_t   [dcache_pkg::NUM_PORTS-1:0] rd_off_i,
  // tag arrives one cycle after the grant
  input  dcache_pkg::tag_t   [dcache_pkg::NUM_PORTS-1:0] rd_tag_i,
  output dcache_pkg::port_oh_t                           rd_ack_o,
  output dcache_pkg::way_oh_t                            rd_vld_bits_o,
  output dcache_pkg::way_oh_t                            rd_hit_oh_o,
  output dcache_pkg::word_t                              rd_data_o,
  output logic                                           rd_err_o,
  // full line refill
  input  logic                                           wr_cl_vld_i,
  input  dcache_pkg::way_oh_t                            wr_cl_we_i,
  input  dcache_pkg::tag_t                               wr_cl_tag_i,
  input  dcache_pkg::idx_t                               wr_cl_idx_i,
  input  dcache_pkg::line_t                              wr_cl_data_i,
  input  dcache_pkg::line_be_t                           wr_cl_be_i,
  input  dcache_pkg::way_oh_t                            wr_vld_bits_i,
  // single word write
  input  dcache_pkg::way_oh_t                            wr_req_i,
  output logic                                           wr_ack_o,
  input  dcache_pkg::idx_t                               wr_idx_i,
  input  dcache_pkg::off_t                               wr_off_i,
  input  dcache_pkg::word_t                              wr_data_i,
  input  dcache_pkg::be_t                                wr_be_i
);

  import dcache_pkg::*;

  // arbiter to arrays
  bank_oh_t                  bank_req;
  bank_oh_t                  bank_we;
  idx_t      [NUM_BANKS-1:0] bank_idx;
  way_oh_t                   tag_req;
  logic                      tag_we;
  idx_t                      tag_idx;

  // arbiter to hit selector
  port_sel_t                 rd_sel;
  off_t                      rd_off;
  logic                      lookup;

  // bank write steering and readout
  way_oh_t [NUM_BANKS-1:0]                 bank_way_we;
  be_t     [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_be;
  word_t   [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_wdata;
  word_t   [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_rdata;
  be_t     [NUM_BANKS-1:0][NUM_WAYS-1:0]   bank_err;

  // tag array readout
  tag_t    [NUM_WAYS-1:0] tag_rdata;
  way_oh_t                tag_vld;

  dcache_port_arbiter dcache_port_arbiter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .rd_prio_i   (rd_prio_i),
    .rd_idx_i    (rd_idx_i),
    .rd_off_i    (rd_off_i),
    .wr_cl_vld_i (wr_cl_vld_i),
    .wr_cl_we_i  (wr_cl_we_i),
    .wr_cl_idx_i (wr_cl_idx_i),
    .wr_req_i    (wr_req_i),
    .wr_off_i    (wr_off_i),
    .wr_idx_i    (wr_idx_i),
    .rd_ack_o    (rd_ack_o),
    .rd_sel_o    (rd_sel),
    .rd_off_o    (rd_off),
    .lookup_o    (lookup),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_idx_o  (bank_idx),
    .tag_req_o   (tag_req),
    .tag_we_o    (tag_we),
    .tag_idx_o   (tag_idx),
    .wr_ack_o    (wr_ack_o)
  );

  dcache_tag_array dcache_tag_array_inst (
    .clk_i (clk_i),
    .req_i (tag_req),
    .we_i  (tag_we),
    .idx_i (tag_idx),
    .tag_i (wr_cl_tag_i),
    .vld_i (wr_vld_bits_i),
    .tag_o (tag_rdata),
    .vld_o (tag_vld)
  );

  ////////////////////
  // data banks
  ////////////////////

  // bank k holds word k of every line, for all ways
  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_banks
    for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_ways
      // refill takes its slice of the line, else the single word
      assign bank_be[k][j]    = wr_cl_vld_i ? wr_cl_be_i[k*WORD_BYTES +: WORD_BYTES] : wr_be_i;
      assign bank_wdata[k][j] = wr_cl_vld_i ? wr_cl_data_i[k*WORD_WIDTH +: WORD_WIDTH]
                                            : wr_data_i;
    end

    assign bank_way_we[k] = wr_cl_vld_i ? wr_cl_we_i : wr_req_i;

    dcache_data_bank dcache_data_bank_inst (
      .clk_i    (clk_i),
      .req_i    (bank_req[k]),
      .we_i     (bank_we[k]),
      .idx_i    (bank_idx[k]),
      .way_we_i (bank_way_we[k]),
      .be_i     (bank_be[k]),
      .wdata_i  (bank_wdata[k]),
      .rdata_o  (bank_rdata[k]),
      .err_o    (bank_err[k])
    );
  end

  dcache_hit_select dcache_hit_select_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .rd_sel_i      (rd_sel),
    .rd_off_i      (rd_off),
    .rd_tag_i      (rd_tag_i),
    .tag_i         (tag_rdata),
    .vld_i         (tag_vld),
    .bank_rdata_i  (bank_rdata),
    .bank_err_i    (bank_err),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o),
    .rd_err_o      (rd_err_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_dcache_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_mem;

  import dcache_pkg::*;

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned RST_CYCLES = 8;
  localparam int unsigned NUM_OPS    = 26;
  localparam int unsigned MAX_TRIES  = 8;

  // operation codes of the table
  localparam logic [2:0] OP_REFILL    = 3'd0;
  localparam logic [2:0] OP_READ      = 3'd1;
  localparam logic [2:0] OP_WRITE     = 3'd2;
  localparam logic [2:0] OP_REFILL_RD = 3'd3;
  localparam logic [2:0] OP_WRITE_RD  = 3'd4;
  localparam logic [2:0] OP_FLIP_TAG  = 3'd5;
  localparam logic [2:0] OP_FLIP_DATA = 3'd6;

  // read port p uses off plus p words
  // the word write uses woff
  typedef struct packed {
    logic [2:0] op;
    port_oh_t   ports;
    port_oh_t   prio;
    idx_t       idx;
    off_t       off;
    off_t       woff;
    tag_t       tag;
    way_oh_t    ways;
    way_oh_t    vld;
    line_be_t   be;
  } op_entry_t;

  logic                        clk_i;
  logic                        rst_ni;
  port_oh_t                    rd_req_i;
  port_oh_t                    rd_prio_i;
  idx_t      [NUM_PORTS-1:0]   rd_idx_i;
  off_t      [NUM_PORTS-1:0]   rd_off_i;
  tag_t      [NUM_PORTS-1:0]   rd_tag_i;
  port_oh_t                    rd_ack_o;
  way_oh_t                     rd_vld_bits_o;
  way_oh_t                     rd_hit_oh_o;
  word_t                       rd_data_o;
  logic                        rd_err_o;
  logic                        wr_cl_vld_i;
  way_oh_t                     wr_cl_we_i;
  tag_t                        wr_cl_tag_i;
  idx_t                        wr_cl_idx_i;
  line_t                       wr_cl_data_i;
  line_be_t                    wr_cl_be_i;
  way_oh_t                     wr_vld_bits_i;
  way_oh_t                     wr_req_i;
  logic                        wr_ack_o;
  idx_t                        wr_idx_i;
  off_t                        wr_off_i;
  word_t                       wr_data_i;
  be_t                         wr_be_i;

  op_entry_t ops [NUM_OPS];
  integer    seed;
  int        errors;

  ////////////////////
  // reference model
  ////////////////////

  tag_t      m_tag     [NUM_SETS][NUM_WAYS];
  logic      m_vld     [NUM_SETS][NUM_WAYS];
  logic      m_tag_bad [NUM_SETS][NUM_WAYS];
  word_t     m_data    [NUM_SETS][NUM_WAYS][NUM_BANKS];
  be_t       m_bad     [NUM_SETS][NUM_WAYS][NUM_BANKS];
  port_sel_t rr_model;
  tag_t      cur_tag;

  // expected values of the lookup granted one cycle back
  logic      pend_vld;
  port_sel_t pend_port;
  tag_t      pend_tag;
  way_oh_t   pend_hit;
  way_oh_t   pend_vbits;
  word_t     pend_data;
  logic      pend_err;

  dcache_mem dcache_mem_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_tag_i      (rd_tag_i),
    .rd_ack_o      (rd_ack_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o),
    .rd_err_o      (rd_err_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .wr_cl_be_i    (wr_cl_be_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_req_i      (wr_req_i),
    .wr_ack_o      (wr_ack_o),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i)
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ten cycles per table entry plus the reset
  initial begin : watchdog
    #((NUM_OPS * 10 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the operation table did not complete in time");
    $display("** FAIL **");
    $finish;
  end

  task automatic report_value(input string msg);
    $display("FAILED @ %0t: %s", $time, msg);
    errors++;
  endtask

  // expected result of a lookup from the model state at grant time
  task automatic expect_lookup(input idx_t idx, input bank_sel_t bank, input tag_t tag);
    pend_vbits = '0;
    pend_hit   = '0;
    pend_data  = '0;
    pend_err   = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      // bad tag parity reads as invalid
      pend_vbits[w] = m_vld[idx][w] & ~m_tag_bad[idx][w];
      if (pend_vbits[w] && (m_tag[idx][w] == tag)) begin
        pend_hit[w] = 1'b1;
        pend_data   = pend_data | m_data[idx][w][bank];
        pend_err    = pend_err | (|m_bad[idx][w][bank]);
      end
    end
  endtask

  task automatic refill_model;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_cl_we_i[w]) begin
        m_tag[wr_cl_idx_i][w]     = wr_cl_tag_i;
        m_vld[wr_cl_idx_i][w]     = wr_vld_bits_i[w];
        m_tag_bad[wr_cl_idx_i][w] = 1'b0;
        for (int k = 0; k < NUM_BANKS; k++) begin
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (wr_cl_be_i[k*WORD_BYTES + b]) begin
              m_data[wr_cl_idx_i][w][k][b*8 +: 8] = wr_cl_data_i[k*WORD_WIDTH + b*8 +: 8];
              m_bad[wr_cl_idx_i][w][k][b]         = 1'b0;
            end
          end
        end
      end
    end
  endtask

  task automatic write_model;
    bank_sel_t bank;
    bank = bank_sel_t'(wr_off_i / WORD_BYTES);
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (wr_req_i[w] && wr_be_i[b]) begin
          m_data[wr_idx_i][w][bank][b*8 +: 8] = wr_data_i[b*8 +: 8];
          m_bad[wr_idx_i][w][bank][b]         = 1'b0;
        end
      end
    end
  endtask

  ////////////////////
  // one clock cycle
  ////////////////////

  // runs from one falling edge to the next with the inputs already driven
  task automatic step(output port_oh_t ack_exp, output logic wr_ack_exp);
    port_oh_t    prio_req;
    port_oh_t    masked;
    int unsigned cand;
    logic        gnt;
    port_sel_t   sel;
    bank_sel_t   rbank;
    bank_sel_t   wbank;
    // only the pending port carries the right tag
    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_tag_i[p] = ~pend_tag;
    end
    if (pend_vld) begin
      rd_tag_i[pend_port] = pend_tag;
    end
    #1;
    // prio requests mask the others before the round robin pick
    prio_req = rd_req_i & rd_prio_i;
    masked   = (|prio_req) ? prio_req : rd_req_i;
    gnt      = 1'b0;
    sel      = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      cand = (int'(rr_model) + i) % NUM_PORTS;
      if (!gnt && masked[cand]) begin
        gnt = 1'b1;
        sel = port_sel_t'(cand);
      end
    end
    gnt     = gnt & ~wr_cl_vld_i;
    ack_exp = '0;
    if (gnt) begin
      ack_exp[sel] = 1'b1;
    end
    rbank      = bank_sel_t'(rd_off_i[sel] / WORD_BYTES);
    wbank      = bank_sel_t'(wr_off_i / WORD_BYTES);
    wr_ack_exp = (|wr_req_i) && !wr_cl_vld_i && !(gnt && (rbank == wbank));

    if (rd_ack_o !== ack_exp) begin
      report_value($sformatf("rd_ack_o %b, expected %b", rd_ack_o, ack_exp));
    end
    if (wr_ack_o !== wr_ack_exp) begin
      report_value($sformatf("wr_ack_o %b, expected %b", wr_ack_o, wr_ack_exp));
    end

    // result of last cycle's grant
    if (pend_vld) begin
      if (rd_hit_oh_o !== pend_hit) begin
        report_value($sformatf("rd_hit_oh_o %b, expected %b", rd_hit_oh_o, pend_hit));
      end
      if (rd_vld_bits_o !== pend_vbits) begin
        report_value($sformatf("rd_vld_bits_o %b, expected %b", rd_vld_bits_o, pend_vbits));
      end
      if (rd_data_o !== pend_data) begin
        report_value($sformatf("rd_data_o %h, expected %h", rd_data_o, pend_data));
      end
      if (rd_err_o !== pend_err) begin
        report_value($sformatf("rd_err_o %b, expected %b", rd_err_o, pend_err));
      end
    end else if (rd_hit_oh_o !== '0) begin
      report_value($sformatf("rd_hit_oh_o %b without a lookup", rd_hit_oh_o));
    end

    // capture before this cycle's writes reach the model
    pend_vld = gnt;
    if (gnt) begin
      pend_port = sel;
      pend_tag  = cur_tag;
      expect_lookup(rd_idx_i[sel], rbank, cur_tag);
      rr_model = port_sel_t'((int'(sel) + 1) % NUM_PORTS);
    end
    if (wr_cl_vld_i) begin
      refill_model();
    end
    if (wr_ack_exp) begin
      write_model();
    end
    @(negedge clk_i);
  endtask

  task automatic drive_idle;
    rd_req_i    = '0;
    rd_prio_i   = '0;
    wr_cl_vld_i = 1'b0;
    wr_req_i    = '0;
  endtask

  task automatic run_op(input op_entry_t e);
    port_oh_t    rd_pend;
    logic        wr_pend;
    logic        cl;
    port_oh_t    ack_exp;
    logic        wr_ack_exp;
    int unsigned tries;
    int          way;
    bank_sel_t   bank;
    way = 0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (e.ways[w]) begin
        way = w;
      end
    end
    bank = bank_sel_t'(e.off / WORD_BYTES);

    // parity faults injected straight into the arrays
    if (e.op == OP_FLIP_TAG) begin
      dcache_mem_inst.dcache_tag_array_inst.mem_q[e.idx][way] =
        dcache_mem_inst.dcache_tag_array_inst.mem_q[e.idx][way] ^ 11'h001;
      m_tag_bad[e.idx][way] = 1'b1;
      return;
    end
    if (e.op == OP_FLIP_DATA) begin
      case (bank)
        2'd0: dcache_mem_inst.gen_banks[0].dcache_data_bank_inst.mem_q[e.idx][way] =
                dcache_mem_inst.gen_banks[0].dcache_data_bank_inst.mem_q[e.idx][way] ^ 36'h1;
        2'd1: dcache_mem_inst.gen_banks[1].dcache_data_bank_inst.mem_q[e.idx][way] =
                dcache_mem_inst.gen_banks[1].dcache_data_bank_inst.mem_q[e.idx][way] ^ 36'h1;
        2'd2: dcache_mem_inst.gen_banks[2].dcache_data_bank_inst.mem_q[e.idx][way] =
                dcache_mem_inst.gen_banks[2].dcache_data_bank_inst.mem_q[e.idx][way] ^ 36'h1;
        default: dcache_mem_inst.gen_banks[3].dcache_data_bank_inst.mem_q[e.idx][way] =
                dcache_mem_inst.gen_banks[3].dcache_data_bank_inst.mem_q[e.idx][way] ^ 36'h1;
      endcase
      // data bit 0 flips and byte 0 parity no longer matches
      m_data[e.idx][way][bank][0] = ~m_data[e.idx][way][bank][0];
      m_bad[e.idx][way][bank][0]  = ~m_bad[e.idx][way][bank][0];
      return;
    end

    cl      = (e.op == OP_REFILL) || (e.op == OP_REFILL_RD);
    rd_pend = (e.op == OP_READ || e.op == OP_REFILL_RD || e.op == OP_WRITE_RD) ? e.ports : '0;
    wr_pend = (e.op == OP_WRITE) || (e.op == OP_WRITE_RD);
    cur_tag = e.tag;

    for (int p = 0; p < NUM_PORTS; p++) begin
      rd_idx_i[p] = e.idx;
      rd_off_i[p] = off_t'(e.off + p * WORD_BYTES);
    end
    wr_cl_we_i    = e.ways;
    wr_cl_tag_i   = e.tag;
    wr_cl_idx_i   = e.idx;
    wr_cl_be_i    = e.be;
    wr_vld_bits_i = e.vld;
    wr_cl_data_i  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    wr_idx_i      = e.idx;
    wr_off_i      = e.woff;
    wr_be_i       = e.be[WORD_BYTES-1:0];
    wr_data_i     = $random(seed);

    // requesters hold until acked while a refill strobes once
    tries = 0;
    while (cl || (rd_pend != '0) || wr_pend) begin
      wr_cl_vld_i = cl;
      rd_req_i    = rd_pend;
      rd_prio_i   = e.prio;
      wr_req_i    = wr_pend ? e.ways : '0;
      step(ack_exp, wr_ack_exp);
      rd_pend = rd_pend & ~ack_exp;
      if (wr_ack_exp) begin
        wr_pend = 1'b0;
      end
      cl = 1'b0;
      tries++;
      if (tries > MAX_TRIES) begin
        $display("request still not acknowledged after %0d cycles", tries);
        errors++;
        break;
      end
    end
    drive_idle();
  endtask

  task automatic load_table;
    // invalidate every way of the two sets in use
    ops[0]  = '{OP_REFILL,    3'b000, 3'b000, 4'd3, 4'd0,  4'd0,  8'h00, 4'hF, 4'h0, 16'hFFFF};
    ops[1]  = '{OP_REFILL,    3'b000, 3'b000, 4'd5, 4'd0,  4'd0,  8'h00, 4'hF, 4'h0, 16'hFFFF};
    ops[2]  = '{OP_REFILL,    3'b000, 3'b000, 4'd3, 4'd0,  4'd0,  8'h5A, 4'h2, 4'h2, 16'hFFFF};
    ops[3]  = '{OP_REFILL,    3'b000, 3'b000, 4'd3, 4'd0,  4'd0,  8'hA5, 4'h4, 4'h4, 16'hFFFF};
    ops[4]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd0,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[5]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd4,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[6]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd8,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[7]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd12, 4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[8]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd6,  4'd0,  8'hA5, 4'h0, 4'h0, 16'h0000};
    // tag absent from the set
    ops[9]  = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd0,  4'd0,  8'h77, 4'h0, 4'h0, 16'h0000};
    ops[10] = '{OP_REFILL_RD, 3'b111, 3'b000, 4'd5, 4'd0,  4'd0,  8'h3C, 4'h1, 4'h1, 16'hFFFF};
    // concurrent reads under several prio masks
    ops[11] = '{OP_READ,      3'b111, 3'b001, 4'd5, 4'd4,  4'd0,  8'h3C, 4'h0, 4'h0, 16'h0000};
    ops[12] = '{OP_READ,      3'b111, 3'b101, 4'd3, 4'd0,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[13] = '{OP_READ,      3'b110, 3'b000, 4'd3, 4'd4,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    // partial word write and merged readback
    ops[14] = '{OP_WRITE,     3'b000, 3'b000, 4'd3, 4'd0,  4'd4,  8'h00, 4'h2, 4'h0, 16'h0005};
    ops[15] = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd4,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    // write against the read bank waits a cycle
    ops[16] = '{OP_WRITE_RD,  3'b001, 3'b000, 4'd3, 4'd8,  4'd8,  8'h5A, 4'h2, 4'h0, 16'h000F};
    ops[17] = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd8,  4'd0,  8'h5A, 4'h0, 4'h0, 16'h0000};
    ops[18] = '{OP_WRITE_RD,  3'b001, 3'b000, 4'd3, 4'd0,  4'd12, 8'h5A, 4'h4, 4'h0, 16'h000C};
    ops[19] = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd12, 4'd0,  8'hA5, 4'h0, 4'h0, 16'h0000};
    ops[20] = '{OP_FLIP_TAG,  3'b000, 3'b000, 4'd3, 4'd0,  4'd0,  8'h00, 4'h4, 4'h0, 16'h0000};
    ops[21] = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd12, 4'd0,  8'hA5, 4'h0, 4'h0, 16'h0000};
    ops[22] = '{OP_FLIP_DATA, 3'b000, 3'b000, 4'd5, 4'd8,  4'd0,  8'h00, 4'h1, 4'h0, 16'h0000};
    // port 1 reads word 2 of set 5
    ops[23] = '{OP_READ,      3'b010, 3'b000, 4'd5, 4'd4,  4'd0,  8'h3C, 4'h0, 4'h0, 16'h0000};
    ops[24] = '{OP_REFILL,    3'b000, 3'b000, 4'd3, 4'd0,  4'd0,  8'hA5, 4'h4, 4'h4, 16'hFFFF};
    ops[25] = '{OP_READ,      3'b001, 3'b000, 4'd3, 4'd12, 4'd0,  8'hA5, 4'h0, 4'h0, 16'h0000};
  endtask

  initial begin : stimulus
    port_oh_t ack_exp;
    logic     wr_ack_exp;
    seed          = 32'h441;
    errors        = 0;
    rr_model      = '0;
    pend_vld      = 1'b0;
    pend_port     = '0;
    pend_tag      = '0;
    cur_tag       = '0;
    rst_ni        = 1'b0;
    rd_idx_i      = '0;
    rd_off_i      = '0;
    rd_tag_i      = '0;
    wr_cl_we_i    = '0;
    wr_cl_tag_i   = '0;
    wr_cl_idx_i   = '0;
    wr_cl_data_i  = '0;
    wr_cl_be_i    = '0;
    wr_vld_bits_i = '0;
    wr_idx_i      = '0;
    wr_off_i      = '0;
    wr_data_i     = '0;
    wr_be_i       = '0;
    drive_idle();
    load_table();

    repeat (RST_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_OPS; i++) begin
      run_op(ops[i]);
    end
    // drain the last lookup
    step(ack_exp, wr_ack_exp);

    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/dcache_pkg.sv
rtl/dcache_data_bank.sv
rtl/dcache_tag_array.sv
rtl/dcache_port_arbiter.sv
rtl/dcache_hit_select.sv
rtl/dcache_mem.sv
testbench/tb_dcache_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_dcache_mem
FILELIST  := sources.f
VFLAGS    := --binary --timing -Wno-fatal -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := ** PASS **

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
